//--- verilog.f
design/execPkg.sv
design/unitConfig.sv
design/execControl.sv
design/barrelShift.sv
design/mulUnit.sv
design/execCluster.sv
tb/tb_execCluster.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build the execution cluster testbench with Verilator and run it.
# Exit status is nonzero when the build fails or a check fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f verilog.f --top-module tb_execCluster \
   && ./obj_dir/Vtb_execCluster \
   || { echo "Simulation run failed"; exit 1; }

//--- tb/tb_execCluster.sv
// Directed testbench for the shift and multiply execution cluster
// Runs shifts, multiplies, stalled back-to-back issues and illegal
// cases, and checks each response against a model of the
// instruction rules

`timescale 1ns/1ps

module tb_execCluster;

   import execPkg::*;

   // Clock and reset
   logic        gclk;
   logic        grst;
   // DUT inputs
   logic        dena;
   logic        issue;
   execReqT     req;
   logic        cfgWe;
   unitCfgT     cfgData;
   // DUT outputs
   logic [31:0] result;
   logic        resValid;
   logic        illegal;
   unitCfgT     cfgRd;

   // LCG state, fixed seed
   logic [31:0] lcgState = 32'd13;

   execCluster #(
      .SHIFT_PRESENT(1'b1),
      .MUL_PRESENT  (1'b1)
   ) uut (
      .gclk    (gclk),
      .grst    (grst),
      .dena    (dena),
      .issue   (issue),
      .req     (req),
      .cfgWe   (cfgWe),
      .cfgData (cfgData),
      .result  (result),
      .resValid(resValid),
      .illegal (illegal),
      .cfgRd   (cfgRd)
   );

   // 10 ns clock
   initial begin
      gclk = 1'b0;
      forever #5 gclk = ~gclk;
   end

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Expected word for a legal operation
   function automatic logic [31:0] modelOp(input logic [5:0] opc, input logic [1:0] st,
         input logic [31:0] a, input logic [31:0] b);
      logic [63:0] prod;
      logic [4:0]  n;
      logic [31:0] r;
      // Only five bits of the amount count
      n = b[4:0];
      prod = {32'd0, a} * {32'd0, b};
      if (opc == OPC_MUL || opc == OPC_MULI) begin
         r = prod[31:0];
      end else if (st == 2'd0) begin
         r = a >> n;
      end else if (st == 2'd1) begin
         r = a >> n;
         // Copies of bit 31 fill from the left
         if (a[31]) begin
            r = r | ~(32'hffff_ffff >> n);
         end
      end else begin
         r = a << n;
      end
      return r;
   endfunction

   task automatic stopOnError(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         stopOnError($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stopOnError($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic checkCfg(input string name, input unitCfgT got, input unitCfgT exp);
      if (got !== exp) begin
         stopOnError($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   // One request on the next edge, dena high
   task automatic issueReq(input logic [5:0] opc, input logic [1:0] st,
         input logic [31:0] a, input logic [31:0] b);
      dena  = 1'b1;
      issue = 1'b1;
      req   = '{opA: a, opB: b, opc: opc, shType: st};
      @(posedge gclk);
      #1;
      issue = 1'b0;
   endtask

   task automatic waitResult();
      int waited;
      waited = 0;
      while (resValid !== 1'b1) begin
         if (waited >= 20) begin
            stopOnError("Timed out after 20 cycles waiting for resValid");
         end
         @(posedge gclk);
         #1;
         waited++;
      end
   endtask

   // Issue, wait, compare; illegal ops return zero
   task automatic runOp(input logic [5:0] opc, input logic [1:0] st, input logic [31:0] a,
         input logic [31:0] b, input logic expIll);
      logic [31:0] expRes;
      expRes = expIll ? 32'd0 : modelOp(opc, st, a, b);
      issueReq(opc, st, a, b);
      waitResult();
      checkFlag("illegal", illegal, expIll);
      checkWord("result", result, expRes);
   endtask

   // Both units built, so readback equals the written value
   task automatic writeCfg(input unitCfgT val);
      cfgWe   = 1'b1;
      cfgData = val;
      @(posedge gclk);
      #1;
      cfgWe = 1'b0;
      checkCfg("cfgRd", cfgRd, val);
   endtask

   task automatic testReset();
      checkFlag("resValid", resValid, 1'b0);
      checkFlag("illegal", illegal, 1'b0);
      checkWord("result", result, 32'd0);
      checkCfg("cfgRd", cfgRd, unitCfgT'{shiftEn: 1'b1, mulEn: 1'b1});
   endtask

   task automatic testLogicalShifts();
      int          i;
      logic [31:0] a;
      logic [31:0] b;
      for (i = 0; i < 8; i++) begin
         a = nextRand();
         b = nextRand();
         runOp((i % 2 == 0) ? OPC_BS : OPC_BSI, 2'd0, a, b, 1'b0);
         runOp((i % 2 == 0) ? OPC_BSI : OPC_BS, 2'd2, a, b, 1'b0);
      end
      // Amounts above 31 wrap to their low five bits
      runOp(OPC_BSI, 2'd0, 32'hdead_beef, 32'd37, 1'b0);
      runOp(OPC_BS, 2'd2, 32'hdead_beef, 32'hffff_ffe5, 1'b0);
   endtask

   task automatic testArithShift();
      int          i;
      logic [31:0] a;
      for (i = 0; i < 6; i++) begin
         a = nextRand() | 32'h8000_0000;
         runOp(OPC_BS, 2'd1, a, nextRand(), 1'b0);
      end
      // Zero amount, also through bit 5 set
      a = nextRand() | 32'h8000_0000;
      issueReq(OPC_BSI, 2'd1, a, 32'd0);
      waitResult();
      checkWord("result", result, a);
      issueReq(OPC_BSI, 2'd1, a, 32'd32);
      waitResult();
      checkWord("result", result, a);
   endtask

   task automatic testMultiply();
      int i;
      for (i = 0; i < 6; i++) begin
         runOp((i % 2 == 0) ? OPC_MUL : OPC_MULI, 2'd0, nextRand(), nextRand(), 1'b0);
      end
      // Low word of a full-width product
      runOp(OPC_MULI, 2'd0, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
   endtask

   // Back-to-back issues with random stalls, results in order
   task automatic testStall();
      int          issued;
      int          seen;
      int          cycles;
      int          denaEdges;
      int          i;
      logic [31:0] expQ[$];
      int          edgeQ[$];
      logic [31:0] pick;
      logic [31:0] a;
      logic [31:0] b;
      logic [5:0]  opc;
      issued    = 0;
      seen      = 0;
      cycles    = 0;
      denaEdges = 0;
      while (seen < 12) begin
         if (cycles >= 400) begin
            stopOnError("Timed out waiting for results of stalled issues");
         end
         cycles++;
         // About one cycle in three stalled
         dena  = ((nextRand() >> 16) % 32'd3) != 32'd0;
         issue = 1'b0;
         if (dena && issued < 12) begin
            pick = (nextRand() >> 16) % 32'd4;
            a    = nextRand();
            b    = nextRand();
            opc  = (pick == 3) ? OPC_MUL : OPC_BS;
            req  = '{opA: a, opB: b, opc: opc, shType: pick[1:0]};
            issue = 1'b1;
            expQ.push_back(modelOp(opc, pick[1:0], a, b));
            issued++;
         end
         @(posedge gclk);
         if (dena) begin
            denaEdges++;
         end
         if (issue) begin
            edgeQ.push_back(denaEdges);
         end
         #1;
         // New result only after a dena edge, held flags are not counted
         if (dena && resValid) begin
            if (expQ.size() == 0) begin
               stopOnError("resValid high with no operation in flight");
            end
            checkFlag("illegal", illegal, 1'b0);
            checkWord("result", result, expQ.pop_front());
            // Issue edge and result edge are consecutive dena edges
            if (denaEdges - edgeQ.pop_front() != 1) begin
               stopOnError("Result did not arrive two dena edges after issue");
            end
            seen++;
         end
      end
      // Pipeline drains, no extra resValid
      dena  = 1'b1;
      issue = 1'b0;
      for (i = 0; i < 3; i++) begin
         @(posedge gclk);
         #1;
         checkFlag("resValid", resValid, 1'b0);
      end
   endtask

   task automatic testIllegal();
      logic [31:0] a;
      logic [31:0] b;
      a = nextRand();
      b = nextRand();
      // Undefined shift type
      runOp(OPC_BS, 2'd3, a, b, 1'b1);
      // Shifter disabled, multiplier untouched
      writeCfg(unitCfgT'{shiftEn: 1'b0, mulEn: 1'b1});
      runOp(OPC_BSI, 2'd0, a, b, 1'b1);
      runOp(OPC_MUL, 2'd0, a, b, 1'b0);
      // Multiplier disabled
      writeCfg(unitCfgT'{shiftEn: 1'b1, mulEn: 1'b0});
      runOp(OPC_MULI, 2'd0, a, b, 1'b1);
      runOp(OPC_BS, 2'd1, a, b, 1'b0);
      // Both back on
      writeCfg(unitCfgT'{shiftEn: 1'b1, mulEn: 1'b1});
      runOp(OPC_BSI, 2'd0, a, b, 1'b0);
      runOp(OPC_MULI, 2'd0, a, b, 1'b0);
   endtask

   initial begin
      grst    = 1'b1;
      dena    = 1'b0;
      issue   = 1'b0;
      req     = '0;
      cfgWe   = 1'b0;
      cfgData = '0;
      repeat (5) @(posedge gclk);
      #1;
      grst = 1'b0;
      dena = 1'b1;
      testReset();
      testLogicalShifts();
      testArithShift();
      testMultiply();
      testStall();
      testIllegal();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

//--- design/execCluster.sv
// Shift and multiply execution cluster
// Top level of the two-stage cluster. Joins the configuration
// register, the control block and the two arithmetic units.
// A unit not built has its result tied to zero.

`timescale 1ns/1ps

module execCluster #(
   parameter bit SHIFT_PRESENT = 1'b1,
   parameter bit MUL_PRESENT   = 1'b1
) (
   input  logic             gclk,
   input  logic             grst,
   input  logic             dena,
   input  logic             issue,
   input  execPkg::execReqT req,
   input  logic             cfgWe,
   input  execPkg::unitCfgT cfgData,
   output logic [31:0]      result,
   output logic             resValid,
   output logic             illegal,
   output execPkg::unitCfgT cfgRd
);

   import execPkg::*;

   unitCfgT     cfg;
   execOpE      shOp;
   logic [31:0] shRes;
   logic [31:0] mulRes;

   unitConfig #(
      .SHIFT_PRESENT(SHIFT_PRESENT),
      .MUL_PRESENT  (MUL_PRESENT)
   ) uConfig (
      .gclk   (gclk),
      .grst   (grst),
      .cfgWe  (cfgWe),
      .cfgData(cfgData),
      .cfg    (cfg)
   );

   // Readback of the masked enables
   assign cfgRd = cfg;

   execControl uControl (
      .gclk    (gclk),
      .grst    (grst),
      .dena    (dena),
      .issue   (issue),
      .opc     (req.opc),
      .shType  (req.shType),
      .cfg     (cfg),
      .shRes   (shRes),
      .mulRes  (mulRes),
      .shOp    (shOp),
      .result  (result),
      .resValid(resValid),
      .illegal (illegal)
   );

   // Shifter only when present
   if (SHIFT_PRESENT) begin : genShift
      barrelShift uShift (
         .gclk (gclk),
         .grst (grst),
         .dena (dena),
         .opA  (req.opA),
         .opB  (req.opB),
         .shOp (shOp),
         .shRes(shRes)
      );
   end else begin : genNoShift
      assign shRes = '0;
   end

   // Multiplier only when present
   if (MUL_PRESENT) begin : genMul
      mulUnit uMul (
         .gclk  (gclk),
         .grst  (grst),
         .dena  (dena),
         .opA   (req.opA),
         .opB   (req.opB),
         .mulRes(mulRes)
      );
   end else begin : genNoMul
      assign mulRes = '0;
   end

endmodule

//--- design/mulUnit.sv
// Two-stage 32 by 32 multiplier
// Stage 1 registers the operands, stage 2 registers the low
// word of the product. Upper product word is not produced.

`timescale 1ns/1ps

module mulUnit (
   input  logic        gclk,
   input  logic        grst,
   input  logic        dena,
   input  logic [31:0] opA,
   input  logic [31:0] opB,
   output logic [31:0] mulRes
);

   // Operand registers
   logic [31:0] mulA;
   logic [31:0] mulB;
   // Low product word, sized to 32 bits so only that part is built
   logic [31:0] prodLo;

   assign prodLo = mulA * mulB;

   // Stage 1
   always_ff @(posedge gclk) begin
      if (grst) begin
         mulA <= '0;
         mulB <= '0;
      end else if (dena) begin
         mulA <= opA;
         mulB <= opB;
      end
   end

   // Stage 2
   // Same dena as the shifter so both units stay in step
   always_ff @(posedge gclk) begin
      if (grst) begin
         mulRes <= '0;
      end else if (dena) begin
         mulRes <= prodLo;
      end
   end

endmodule

//--- design/barrelShift.sv
// Two-stage 32-bit barrel shifter
// Stage 1 computes all three shifts of opA by the low five bits
// of opB. Stage 2 picks the one named by the delayed operation.
// Only shift operations ever arrive on shOp.

`timescale 1ns/1ps

module barrelShift (
   input  logic            gclk,
   input  logic            grst,
   input  logic            dena,
   input  logic [31:0]     opA,
   input  logic [31:0]     opB,
   input  execPkg::execOpE shOp,
   output logic [31:0]     shRes
);

   import execPkg::*;

   // Shift amount, upper bits of opB are ignored
   logic [4:0]  shAmt;
   // Candidate shifts held between stages
   logic [31:0] candSrl;
   logic [31:0] candSra;
   logic [31:0] candSll;
   // Operation delayed to stage 2
   execOpE      opS1;

   assign shAmt = opB[4:0];

   // Stage 1 candidates
   always_ff @(posedge gclk) begin
      if (dena) begin
         candSrl <= opA >> shAmt;
         // Sign fill from bit 31
         candSra <= $signed(opA) >>> shAmt;
         candSll <= opA << shAmt;
      end
   end

   // Stage 1 select register
   always_ff @(posedge gclk) begin
      if (grst) begin
         opS1 <= OP_NONE;
      end else if (dena) begin
         opS1 <= shOp;
      end
   end

   // Stage 2 output register
   always_ff @(posedge gclk) begin
      if (dena) begin
         case (opS1)
            OP_SRL: shRes <= candSrl;
            OP_SRA: shRes <= candSra;
            OP_SLL: shRes <= candSll;
            // Not a shift, control drops this word anyway
            default: shRes <= '0;
         endcase
      end
   end

   // Control must keep multiply and illegal ops off this port,
   // so a live select is always one of the three shifts
   assert property (@(posedge gclk) disable iff (grst)
      (dena && opS1 != OP_NONE) |-> (opS1 inside {OP_SRL, OP_SRA, OP_SLL}))
      else $error("barrelShift: stage 2 select is not a shift");

endmodule

//--- design/execControl.sv
// Execution cluster control
// Decodes each request into an operation, carries it through the
// two pipeline stages beside the arithmetic units, selects the
// result word and raises illegal for shifts with a bad type field
// or operations on a disabled unit.

`timescale 1ns/1ps

module execControl (
   input  logic             gclk,
   input  logic             grst,
   input  logic             dena,
   input  logic             issue,
   input  logic [5:0]       opc,
   input  logic [1:0]       shType,
   input  execPkg::unitCfgT cfg,
   input  logic [31:0]      shRes,
   input  logic [31:0]      mulRes,
   output execPkg::execOpE  shOp,
   output logic [31:0]      result,
   output logic             resValid,
   output logic             illegal
);

   import execPkg::*;

   // Decoded operation of the request at the input
   execOpE opDec;
   // Operation in stage 1 and stage 2
   execOpE opS1;
   execOpE opS2;

   // Request decode
   always_comb begin
      opDec = OP_NONE;
      if (issue) begin
         case (opc)
            OPC_BS, OPC_BSI: begin
               if (!cfg.shiftEn) begin
                  opDec = OP_ILL;
               end else begin
                  case (shType)
                     2'd0: opDec = OP_SRL;
                     2'd1: opDec = OP_SRA;
                     2'd2: opDec = OP_SLL;
                     default: opDec = OP_ILL;
                  endcase
               end
            end
            OPC_MUL, OPC_MULI: begin
               opDec = cfg.mulEn ? OP_MUL : OP_ILL;
            end
            // Other opcodes belong to other units
            default: opDec = OP_NONE;
         endcase
      end
   end

   // Shifter only sees real shift operations
   always_comb begin
      case (opDec)
         OP_SRL, OP_SRA, OP_SLL: shOp = opDec;
         default: shOp = OP_NONE;
      endcase
   end

   // Operation pipeline, holds while dena is low
   always_ff @(posedge gclk) begin
      if (grst) begin
         opS1     <= OP_NONE;
         opS2     <= OP_NONE;
         resValid <= 1'b0;
         illegal  <= 1'b0;
      end else if (dena) begin
         opS1     <= opDec;
         opS2     <= opS1;
         // Flags move with the stage 2 operation
         resValid <= (opS1 != OP_NONE);
         illegal  <= (opS1 == OP_ILL);
      end
   end

   // Result select from stage 2
   // Unit outputs are registered on the same edge as opS2
   always_comb begin
      case (opS2)
         OP_SRL, OP_SRA, OP_SLL: result = shRes;
         OP_MUL: result = mulRes;
         // Empty slot and illegal both give zero
         default: result = '0;
      endcase
   end

   // No flag without an operation behind it in stage 2
   assert property (@(posedge gclk) disable iff (grst)
      (opS2 == OP_NONE) |-> (!resValid && !illegal))
      else $error("execControl: flag raised for empty stage 2");

endmodule

//--- design/unitConfig.sv
// Unit configuration register
// Holds the run-time enables of the barrel shifter and multiplier.
// Enables of units not built are forced low on every write.

`timescale 1ns/1ps

module unitConfig #(
   parameter bit SHIFT_PRESENT = 1'b1,
   parameter bit MUL_PRESENT   = 1'b1
) (
   input  logic             gclk,
   input  logic             grst,
   input  logic             cfgWe,
   input  execPkg::unitCfgT cfgData,
   output execPkg::unitCfgT cfg
);

   // Enable register
   // Write taken on any edge with cfgWe, independent of dena
   always_ff @(posedge gclk) begin
      if (grst) begin
         // Out of reset every built unit is enabled
         cfg.shiftEn <= SHIFT_PRESENT;
         cfg.mulEn   <= MUL_PRESENT;
      end else if (cfgWe) begin
         // Absent unit stays disabled
         cfg.shiftEn <= cfgData.shiftEn & SHIFT_PRESENT;
         cfg.mulEn   <= cfgData.mulEn & MUL_PRESENT;
      end
   end

   // Readback goes straight out through the top level,
   // so the core sees the masked value, not what it wrote

endmodule

//--- design/execPkg.sv
// Shared types for the shift and multiply execution cluster
// Request and configuration structs, decoded operation enum
// and the MicroBlaze major opcodes handled by the cluster

package execPkg;

   // Major opcodes, 6-bit field of the instruction word
   // Register form
   localparam logic [5:0] OPC_MUL  = 6'h10;
   // Immediate form
   localparam logic [5:0] OPC_MULI = 6'h18;
   // Barrel shift, register form
   localparam logic [5:0] OPC_BS   = 6'h11;
   // Barrel shift, immediate form
   localparam logic [5:0] OPC_BSI  = 6'h19;

   // Shift type encodings from instruction bits 10:9
   // 0 logical right, 1 arithmetic right, 2 logical left
   // 3 has no meaning and decodes as illegal

   // One request as issued by the core
   typedef struct packed {
      // First operand
      logic [31:0] opA;
      // Second operand or sign-extended immediate
      logic [31:0] opB;
      // Major opcode
      logic [5:0]  opc;
      // Shift type field
      logic [1:0]  shType;
   } execReqT;

   // Run-time unit enables
   typedef struct packed {
      logic shiftEn;
      logic mulEn;
   } unitCfgT;

   // Decoded operation carried down the pipeline
   typedef enum logic [2:0] {
      // Empty slot, no result expected
      OP_NONE,
      // Logical right
      OP_SRL,
      // Arithmetic right
      OP_SRA,
      // Logical left
      OP_SLL,
      // Low product word
      OP_MUL,
      // Bad shift type or disabled unit
      OP_ILL
   } execOpE;

endpackage
